//--- compile.f
+incdir+verilog
verilog/mulUnitPkg.sv
verilog/mulDecode.sv
verilog/mulArray.sv
verilog/accControl.sv
verilog/mulUnit.sv
testbench/mulUnitTb.sv

//--- testbench/mulUnitTb.sv
/*
 * Directed testbench for the multiply/accumulate unit. A scoreboard checks
 * every strobe for its value and its exact cycle, three edges after launch.
 * Waits are bounded by their own timeouts and by an overall watchdog.
 */

`default_nettype none

`include "mulUnit_defines.svh"

module mulUnitTb
    import mulUnitPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int       CLK_HALF      = 50;
    localparam int       DRIVE_DELAY   = 1;  // Inputs change this long after the edge
    localparam int       PIPE_EDGES    = 3;
    localparam int       DRAIN_TIMEOUT = 20;
    localparam int       WATCHDOG_CYC  = 5000;
    localparam mulFunc_t UNKNOWN_FUNC  = 6'h3f;

    typedef struct packed {
        logic        isResult; // Set for a result strobe
        logic [31:0] cycle;    // Cycle count when the strobe is due
        word_t       word;
        accFlags_t   flags;
    } expEvent_t;

    logic        Clock;
    logic        nReset;
    logic        Valid;
    mulRequest_t Request;
    word_t       Result;
    logic        ResultValid;
    accFlags_t   Flags;
    logic        FlagsValid;

    expEvent_t   expQ[$];     // Outstanding strobes in issue order
    acc_t        modelAcc;
    accFlags_t   modelFlags;
    logic [31:0] cycleCount;
    logic [31:0] rngState;

    mulUnit u_mulUnit (
        .Clock       (Clock),
        .nReset      (nReset),
        .Valid       (Valid),
        .Request     (Request),
        .Result      (Result),
        .ResultValid (ResultValid),
        .Flags       (Flags),
        .FlagsValid  (FlagsValid)
    );

    initial
    begin
        Clock = 1'b0;
        forever #CLK_HALF Clock = ~Clock;
    end

    always @(posedge Clock) cycleCount <= cycleCount + 32'd1;

    // ------------------------------------------------------------------------
    // Reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic stopWithFailure(input string line);
        begin
            $display("%s", line);
            $display("Regression failed");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic checkWord(input word_t actual, input word_t expected, input string what);
        begin
            if (actual !== expected)
                stopWithFailure($sformatf("FAILED at %0d ns: %s is %h, expected %h",
                                          $time, what, actual, expected));
        end
    endtask

    task automatic checkFlags(input accFlags_t actual, input accFlags_t expected,
                              input string what);
        begin
            if (actual !== expected)
                stopWithFailure($sformatf("FAILED at %0d ns: %s CZVN is %b, expected %b",
                                          $time, what, actual, expected));
        end
    endtask

    // Xorshift32 generator
    function automatic word_t nextRandom();
        word_t x;
        begin
            x = rngState;
            x = x ^ (x << 13);
            x = x ^ (x >> 17);
            x = x ^ (x << 5);
            rngState = x;
            return x;
        end
    endfunction

    // ------------------------------------------------------------------------
    // Reference model, applied in issue order
    // ------------------------------------------------------------------------
    task automatic predict(input mulFunc_t func, input word_t rs, input word_t rt,
                           input logic [31:0] due);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        acc_t            prod;
        acc_t            oldAcc;
        expEvent_t       ev;
        logic            flagOp;
        begin
            sa = $signed(rs);
            sb = $signed(rt);
            ua = rs;
            ub = rt;
            if (func == `MULT || func == `MADD || func == `MSUB)
                prod = sa * sb;
            else
                prod = ua * ub;
            oldAcc   = modelAcc;
            ev       = '0;
            ev.cycle = due;
            flagOp   = 1'b1;
            modelFlags.carry    = 1'b0; // Loads and moves clear carry and overflow
            modelFlags.overflow = 1'b0;
            case (func)
                `MULT, `MULTU: modelAcc = prod;
                `MADD, `MADDU:
                begin
                    modelAcc         = oldAcc + prod;
                    modelFlags.carry = (modelAcc < oldAcc); // Wrapped past 2**64
                    if (func == `MADD)
                        modelFlags.overflow = (oldAcc[63] == prod[63]) &&
                                              (modelAcc[63] != oldAcc[63]);
                    else
                        modelFlags.overflow = modelFlags.carry;
                end
                `MSUB, `MSUBU:
                begin
                    modelAcc         = oldAcc - prod;
                    modelFlags.carry = (oldAcc < prod); // Borrow
                    if (func == `MSUB)
                        modelFlags.overflow = (oldAcc[63] != prod[63]) &&
                                              (modelAcc[63] != oldAcc[63]);
                    else
                        modelFlags.overflow = modelFlags.carry;
                end
                `MTHI: modelAcc = {rs, oldAcc[31:0]};
                `MTLO: modelAcc = {oldAcc[63:32], rs};
                default:
                begin
                    flagOp      = 1'b0;
                    ev.isResult = (func == `MFHI || func == `MFLO);
                    ev.word     = (func == `MFHI) ? oldAcc[63:32] : oldAcc[31:0];
                end
            endcase
            if (flagOp)
            begin
                modelFlags.zero     = (modelAcc == '0);
                modelFlags.negative = modelAcc[63];
                ev.flags            = modelFlags;
                expQ.push_back(ev);
            end
            else if (ev.isResult)
                expQ.push_back(ev);    // Unknown codes expect nothing
        end
    endtask

    // Scoreboard samples strobes at the falling edge where they are stable
    always @(negedge Clock)
    begin : scoreboard
        expEvent_t ev;
        if (nReset === 1'b1)
        begin
            if (FlagsValid && ResultValid)
                stopWithFailure("result and flag strobes were both active in one cycle");
            else if (FlagsValid || ResultValid)
            begin
                if (expQ.size() == 0)
                    stopWithFailure("a strobe arrived with no operation outstanding");
                else
                begin
                    ev = expQ.pop_front();
                    if (ev.isResult != ResultValid)
                        stopWithFailure("strobe kind does not match the oldest operation");
                    else if (ev.cycle != cycleCount)
                        stopWithFailure($sformatf("FAILED at %0d ns: strobe in cycle %0d, due in %0d",
                                                  $time, cycleCount, ev.cycle));
                    else if (ev.isResult)
                        checkWord(Result, ev.word, "Result");
                    else
                        checkFlags(Flags, ev.flags, "Flags");
                end
            end
            else if (expQ.size() != 0 && expQ[0].cycle <= cycleCount)
                stopWithFailure("an expected strobe did not arrive in its cycle");
        end
    end

    // ------------------------------------------------------------------------
    // Drive tasks
    // ------------------------------------------------------------------------
    task automatic issueOp(input mulFunc_t func, input word_t rs, input word_t rt);
        begin
            @(posedge Clock);
            #DRIVE_DELAY;
            Valid   = 1'b1;
            Request = '{func: func, rs: rs, rt: rt};
            predict(func, rs, rt, cycleCount + PIPE_EDGES);
        end
    endtask

    task automatic waitDrain();
        int waited;
        begin
            @(posedge Clock);
            #DRIVE_DELAY;
            Valid  = 1'b0;
            waited = 0;
            while (expQ.size() != 0 && waited < DRAIN_TIMEOUT)
            begin
                @(posedge Clock);
                waited++;
            end
            if (expQ.size() != 0)
                stopWithFailure("timed out waiting for outstanding strobes");
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic resetStateReads();
        int i;
        begin
            checkFlags(Flags, '0, "Flags after reset");
            for (i = 0; i < 5; i++)
            begin
                @(negedge Clock);
                if (ResultValid !== 1'b0 || FlagsValid !== 1'b0)
                    stopWithFailure("a strobe was active while nothing was issued");
            end
            issueOp(`MFHI, nextRandom(), nextRandom());
            issueOp(`MFLO, nextRandom(), nextRandom());
            waitDrain();
        end
    endtask

    task automatic movesAndProducts();
        word_t a;
        word_t b;
        int    i;
        begin
            issueOp(`MTHI, nextRandom(), nextRandom());
            issueOp(`MTLO, nextRandom(), nextRandom());
            issueOp(`MFHI, '0, '0);
            issueOp(`MFLO, '0, '0);
            for (i = 0; i < 6; i++)
            begin
                a = nextRandom();
                b = nextRandom();
                a[31] = (i % 2 == 0) ? 1'b1 : a[31]; // Force negative operands
                b[31] = (i % 3 == 0) ? 1'b1 : b[31];
                issueOp((i % 2 == 0) ? `MULT : `MULTU, a, b);
                issueOp(`MFHI, '0, '0);
                issueOp(`MFLO, '0, '0);
            end
            waitDrain();
        end
    endtask

    task automatic accumulateChains();
        mulFunc_t func;
        word_t    r;
        int       i;
        begin
            issueOp(`MULT, nextRandom(), nextRandom());
            for (i = 0; i < 16; i++)
            begin
                r = nextRandom();
                case (r[1:0])
                    2'd0:    func = `MADD;
                    2'd1:    func = `MADDU;
                    2'd2:    func = `MSUB;
                    default: func = `MSUBU;
                endcase
                issueOp(func, nextRandom(), nextRandom());
                if (i % 4 == 3)
                    issueOp(`MFLO, '0, '0);
            end
            // All ones plus one wraps to zero with carry, then borrow from zero
            issueOp(`MTHI, 32'hffffffff, '0);
            issueOp(`MTLO, 32'hffffffff, '0);
            issueOp(`MADDU, 32'd1, 32'd1);
            issueOp(`MSUBU, 32'd1, 32'd1);
            issueOp(`MFHI, '0, '0);
            waitDrain();
        end
    endtask

    task automatic flagCorners();
        word_t a;
        begin
            a = nextRandom();
            issueOp(`MTHI, 32'h7fffffff, '0); // Largest positive, then +1
            issueOp(`MTLO, 32'hffffffff, '0);
            issueOp(`MADD, 32'd1, 32'd1);
            issueOp(`MTHI, 32'h80000000, '0); // Most negative, then -1
            issueOp(`MTLO, '0, '0);
            issueOp(`MSUB, 32'd1, 32'd1);
            issueOp(`MULT, a, '0);
            issueOp(`MULT, a, 32'hfffffffd);
            issueOp(`MSUB, a, 32'hfffffffd);  // Cancels to zero
            waitDrain();
            checkFlags(Flags, '{carry: 1'b0, zero: 1'b1, overflow: 1'b0, negative: 1'b0},
                       "Flags after cancelling MSUB");
        end
    endtask

    task automatic backToBackIssue();
        begin
            issueOp(`MTLO, 32'h10, '0);
            issueOp(`MADD, 32'd3, 32'd5);
            issueOp(`MFLO, '0, '0);
            issueOp(UNKNOWN_FUNC, nextRandom(), nextRandom());
            issueOp(`MADD, 32'hfffffffe, 32'd7);
            issueOp(`MFHI, '0, '0);
            issueOp(`MFLO, '0, '0);
            issueOp(UNKNOWN_FUNC, nextRandom(), nextRandom());
            issueOp(`MSUBU, nextRandom(), nextRandom());
            issueOp(`MFLO, '0, '0);
            issueOp(`MFHI, '0, '0);
            waitDrain();
        end
    endtask

    initial
    begin
        nReset     = 1'b0;
        Valid      = 1'b0;
        Request    = '0;
        cycleCount = '0;
        modelAcc   = '0;
        modelFlags = '0;
        rngState   = 32'h376d2648;
        repeat (3) @(posedge Clock);
        #DRIVE_DELAY;
        nReset = 1'b1;

        resetStateReads();
        movesAndProducts();
        accumulateChains();
        flagCorners();
        backToBackIssue();

        $display("Regression passed");
        $finish;
    end

    initial
    begin : watchdog
        #(WATCHDOG_CYC * 2 * CLK_HALF);
        stopWithFailure("the watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

//--- verilog/mulUnit.sv
/*
 * Multiply/accumulate unit of the execute stage, three stages deep.
 * One operation per cycle, no back-pressure; results and flags come out
 * three edges after issue, in issue order.
 */

`default_nettype none

`include "mulUnit_defines.svh"

module mulUnit
    import mulUnitPkg::*;
(
    input  wire         Clock,
    input  wire         nReset,
    input  wire         Valid,
    input  mulRequest_t Request,
    output word_t       Result,
    output logic        ResultValid,
    output accFlags_t   Flags,
    output logic        FlagsValid
);

    // Decode to multiplier
    logic        decValid;
    mulCtrl_t    decCtrl;
    word_t       rs;
    word_t       rt;

    // Multiplier to accumulator
    logic        opValid;
    accOperand_t operand;

    // ------------------------------------------------------------------------
    // Pipeline stages
    // ------------------------------------------------------------------------
    mulDecode u_mulDecode (
        .Clock    (Clock),
        .nReset   (nReset),
        .Valid    (Valid),
        .Request  (Request),
        .DecValid (decValid),
        .DecCtrl  (decCtrl),
        .Rs       (rs),
        .Rt       (rt)
    );

    mulArray u_mulArray (
        .Clock    (Clock),
        .nReset   (nReset),
        .DecValid (decValid),
        .DecCtrl  (decCtrl),
        .Rs       (rs),
        .Rt       (rt),
        .OpValid  (opValid),
        .Operand  (operand)
    );

    accControl u_accControl (
        .Clock       (Clock),
        .nReset      (nReset),
        .OpValid     (opValid),
        .Operand     (operand),
        .Result      (Result),
        .ResultValid (ResultValid),
        .Flags       (Flags),
        .FlagsValid  (FlagsValid)
    );

endmodule

`default_nettype wire

//--- verilog/accControl.sv
/*
 * Last pipeline stage. Owns the HI/LO accumulator, so dependent operations
 * issued back to back see each other without forwarding.
 * Result is only meaningful while ResultValid is high.
 */

`default_nettype none

`include "mulUnit_defines.svh"

module accControl
    import mulUnitPkg::*;
(
    input  wire         Clock,
    input  wire         nReset,
    input  wire         OpValid,
    input  accOperand_t Operand,
    output word_t       Result,
    output logic        ResultValid,
    output accFlags_t   Flags,
    output logic        FlagsValid
);

    acc_t               acc;       // {HI, LO}
    acc_t               accNext;
    acc_t               opVal;
    logic [`MUL_ACC_W:0] sum;      // One extra bit for carry or borrow
    logic               carry;
    logic               overflow;
    logic               setsFlags;
    logic               readsWord;
    word_t              readWord;
    accFlags_t          flagsNext;

    assign opVal = Operand.operand;

    // ------------------------------------------------------------------------
    // Next accumulator value and flags
    // ------------------------------------------------------------------------
    always_comb
    begin
        accNext   = acc;
        sum       = '0;
        carry     = 1'b0;
        overflow  = 1'b0;
        setsFlags = 1'b0;
        readsWord = 1'b0;
        readWord  = acc[`MUL_ACC_W-1:`MUL_WORD_W];

        if (OpValid)
        begin
            case (Operand.ctrl.accOp)
                ACC_ADD:
                begin
                    sum       = {1'b0, acc} + {1'b0, opVal};
                    accNext   = sum[`MUL_ACC_W-1:0];
                    carry     = sum[`MUL_ACC_W];
                    setsFlags = 1'b1;
                    if (Operand.ctrl.isSigned) // Same-sign inputs, sign flipped
                        overflow = (acc[`MUL_ACC_W-1] == opVal[`MUL_ACC_W-1]) &&
                                   (accNext[`MUL_ACC_W-1] != acc[`MUL_ACC_W-1]);
                    else
                        overflow = carry;
                end
                ACC_SUB:
                begin
                    sum       = {1'b0, acc} - {1'b0, opVal};
                    accNext   = sum[`MUL_ACC_W-1:0];
                    carry     = sum[`MUL_ACC_W];         // Borrow
                    setsFlags = 1'b1;
                    if (Operand.ctrl.isSigned)
                        overflow = (acc[`MUL_ACC_W-1] != opVal[`MUL_ACC_W-1]) &&
                                   (accNext[`MUL_ACC_W-1] != acc[`MUL_ACC_W-1]);
                    else
                        overflow = carry;
                end
                ACC_LOAD:
                begin
                    accNext   = opVal;
                    setsFlags = 1'b1;
                end
                ACC_WRHI:
                begin
                    accNext   = {opVal[`MUL_WORD_W-1:0], acc[`MUL_WORD_W-1:0]};
                    setsFlags = 1'b1;
                end
                ACC_WRLO:
                begin
                    accNext   = {acc[`MUL_ACC_W-1:`MUL_WORD_W], opVal[`MUL_WORD_W-1:0]};
                    setsFlags = 1'b1;
                end
                ACC_RDHI: readsWord = 1'b1; // Old HI, default readWord
                ACC_RDLO:
                begin
                    readsWord = 1'b1;
                    readWord  = acc[`MUL_WORD_W-1:0];
                end
                default: ; // ACC_NONE leaves everything alone
            endcase
        end

        flagsNext = '{carry:    carry,
                      zero:     (accNext == '0),
                      overflow: overflow,
                      negative: accNext[`MUL_ACC_W-1]};
    end

    // ------------------------------------------------------------------------
    // Accumulator and output registers
    // ------------------------------------------------------------------------
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            acc         <= '0;
            Flags       <= '0;
            FlagsValid  <= 1'b0;
            ResultValid <= 1'b0;
        end
        else
        begin
            acc         <= accNext;
            FlagsValid  <= setsFlags;
            ResultValid <= readsWord;
            if (setsFlags)
                Flags <= flagsNext;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (readsWord)
            Result <= readWord;
    end

endmodule

`default_nettype wire

//--- verilog/mulArray.sv
/*
 * Second pipeline stage. One registered 32x32 multiply, signed or unsigned
 * as the control asks. MTHI and MTLO bypass the multiplier and carry Rs
 * in the low word; for reads and unknown codes the operand is don't-care.
 */

`default_nettype none

`include "mulUnit_defines.svh"

module mulArray
    import mulUnitPkg::*;
(
    input  wire         Clock,
    input  wire         nReset,
    input  wire         DecValid,
    input  mulCtrl_t    DecCtrl,
    input  word_t       Rs,
    input  word_t       Rt,
    output logic        OpValid,
    output accOperand_t Operand
);

    acc_t     rsExt;       // Operands widened to product width
    acc_t     rtExt;
    acc_t     product;
    acc_t     operandNext;
    mulCtrl_t opCtrl;
    acc_t     opData;

    // ------------------------------------------------------------------------
    // Multiplier
    // ------------------------------------------------------------------------

    // Sign or zero extend first; the low 64 bits of the 64x64 product are
    // then the correct result for both signed and unsigned operands
    always_comb
    begin
        if (DecCtrl.signedOp)
        begin
            rsExt = {{`MUL_WORD_W{Rs[`MUL_WORD_W-1]}}, Rs};
            rtExt = {{`MUL_WORD_W{Rt[`MUL_WORD_W-1]}}, Rt};
        end
        else
        begin
            rsExt = {{`MUL_WORD_W{1'b0}}, Rs};
            rtExt = {{`MUL_WORD_W{1'b0}}, Rt};
        end
    end

    assign product = rsExt * rtExt; // Truncated to 64 bits

    // Operand select
    always_comb
    begin
        case (DecCtrl.accOp)
            ACC_WRHI,
            ACC_WRLO: operandNext = {{`MUL_WORD_W{1'b0}}, Rs}; // Raw Rs, low word
            default:  operandNext = product;
        endcase
    end

    // ------------------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------------------
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            OpValid <= 1'b0;
            opCtrl  <= '0;
        end
        else
        begin
            OpValid <= DecValid;
            opCtrl  <= DecCtrl;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (DecValid)
        begin
            opData <= operandNext;
        end
    end

    assign Operand = '{ctrl: opCtrl, operand: opData};

endmodule

`default_nettype wire

//--- verilog/mulDecode.sv
/*
 * First pipeline stage. Registers the issued request and turns the
 * function code into multiplier and accumulator controls.
 * Unknown codes travel on as ACC_NONE with DecValid still set.
 */

`default_nettype none

`include "mulUnit_defines.svh"

module mulDecode
    import mulUnitPkg::*;
(
    input  wire         Clock,
    input  wire         nReset,
    input  wire         Valid,
    input  mulRequest_t Request,
    output logic        DecValid,
    output mulCtrl_t    DecCtrl,
    output word_t       Rs,
    output word_t       Rt
);

    mulCtrl_t ctrlNext;

    // ------------------------------------------------------------------------
    // Function code decode
    // ------------------------------------------------------------------------
    always_comb
    begin
        ctrlNext = '{signedOp: 1'b0, accOp: ACC_NONE, isSigned: 1'b0};
        case (Request.func)
            `MULT:  ctrlNext = '{signedOp: 1'b1, accOp: ACC_LOAD, isSigned: 1'b1};
            `MULTU: ctrlNext = '{signedOp: 1'b0, accOp: ACC_LOAD, isSigned: 1'b0};
            `MADD:  ctrlNext = '{signedOp: 1'b1, accOp: ACC_ADD,  isSigned: 1'b1};
            `MADDU: ctrlNext = '{signedOp: 1'b0, accOp: ACC_ADD,  isSigned: 1'b0};
            `MSUB:  ctrlNext = '{signedOp: 1'b1, accOp: ACC_SUB,  isSigned: 1'b1};
            `MSUBU: ctrlNext = '{signedOp: 1'b0, accOp: ACC_SUB,  isSigned: 1'b0};

            // Moves between GPR and HI/LO, no multiply involved
            `MTHI:  ctrlNext.accOp = ACC_WRHI;
            `MTLO:  ctrlNext.accOp = ACC_WRLO;
            `MFHI:  ctrlNext.accOp = ACC_RDHI;
            `MFLO:  ctrlNext.accOp = ACC_RDLO;
            default: ; // Stays ACC_NONE
        endcase
    end

    // ------------------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------------------
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            DecValid <= 1'b0;
            DecCtrl  <= '0;
        end
        else
        begin
            DecValid <= Valid;
            DecCtrl  <= ctrlNext;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (Valid) // Hold operands when idle
        begin
            Rs <= Request.rs;
            Rt <= Request.rt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mulUnitPkg.sv
/*
 * Shared types for the multiply/accumulate unit.
 * accOp encodings are local to this unit and never leave the pipeline.
 */

`default_nettype none

`include "mulUnit_defines.svh"

package mulUnitPkg;

    typedef logic [`MUL_WORD_W-1:0] word_t;    // One register value
    typedef logic [`MUL_ACC_W-1:0]  acc_t;     // Product or HI/LO pair
    typedef logic [`MUL_FUNC_W-1:0] mulFunc_t;
    typedef logic [2:0]             accOp_t;   // Accumulator operation select

    // Accumulator operations, ACC_NONE must stay zero
    localparam accOp_t ACC_NONE = 3'd0;
    localparam accOp_t ACC_LOAD = 3'd1;
    localparam accOp_t ACC_ADD  = 3'd2;
    localparam accOp_t ACC_SUB  = 3'd3;
    localparam accOp_t ACC_WRHI = 3'd4;
    localparam accOp_t ACC_WRLO = 3'd5;
    localparam accOp_t ACC_RDHI = 3'd6;
    localparam accOp_t ACC_RDLO = 3'd7;

    typedef struct packed {
        logic carry;    // Carry out, or borrow on subtract
        logic zero;
        logic overflow;
        logic negative;
    } accFlags_t;

    typedef struct packed {
        mulFunc_t func;
        word_t    rs;
        word_t    rt;
    } mulRequest_t;

    typedef struct packed {
        logic   signedOp; // Multiply treats operands as signed
        accOp_t accOp;
        logic   isSigned; // Signed overflow rule for the flags
    } mulCtrl_t;

    typedef struct packed {
        mulCtrl_t ctrl;
        acc_t     operand; // Product, or Rs in the low word
    } accOperand_t;

endpackage

`default_nettype wire

//--- verilog/mulUnit_defines.svh
/*
 * Widths and function codes for the multiply/accumulate unit.
 * Codes follow the MIPS SPECIAL and SPECIAL2 layout; they only need to be
 * distinct here, since the opcode field is decoded elsewhere in the core.
 */

`ifndef MUL_UNIT_DEFINES_SVH
`define MUL_UNIT_DEFINES_SVH

// ---------------------------------------------------------------------------
// Data widths
// ---------------------------------------------------------------------------
`define MUL_WORD_W 32 // Register width
`define MUL_ACC_W  64 // HI/LO accumulator width
`define MUL_FUNC_W 6  // Function code width

// ---------------------------------------------------------------------------
// Function codes
// ---------------------------------------------------------------------------
`define MADD  6'h00
`define MADDU 6'h01
`define MSUB  6'h04
`define MSUBU 6'h05

`define MFHI  6'h10
`define MTHI  6'h11
`define MFLO  6'h12
`define MTLO  6'h13

`define MULT  6'h18
`define MULTU 6'h19

`endif
